//--- bench/csi2_rx_cases.txt
# name kind(frame nofrm dis) dt(hex) word_count(dec) seed(hex) fault(none ecc1 ecc2 crc)
# Each frame case sends frame start, the long packet, then frame end
wc0_raw8      frame 2A 0  0001 none
wc1_raw8      frame 2A 1  0002 none
wc2_raw8      frame 2A 2  0003 none
wc3_raw8      frame 2A 3  0004 none
wc4_raw10     frame 2B 4  0005 none
wc5_raw10     frame 2B 5  0006 none
wc6_yuv       frame 1E 6  0007 none
wc7_yuv       frame 1E 7  0008 none
wc13_rgb      frame 24 13 0009 none
wc16_rgb      frame 24 16 000A none
wc30_raw8     frame 2A 30 000B none
ecc1_wc10     frame 2A 10 0010 ecc1
ecc1_wc7      frame 2B 7  0011 ecc1
ecc2_wc9      frame 2A 9  0020 ecc2
ecc2_wc4      frame 1E 4  0021 ecc2
crc_wc12      frame 2A 12 0030 crc
crc_wc3       frame 2B 3  0031 crc
crc_wc1       frame 24 1  0032 crc
nofrm_wc8     nofrm 2A 8  0040 none
nofrm_wc5     nofrm 1E 5  0041 none
dis_wc6       dis   2A 6  0050 none
dis_wc11      dis   2B 11 0051 none

//--- csi2_rx.f
src/csi2_rx_pkg.sv
src/csi2_hdr_ecc.sv
src/csi2_pkt_framer.sv
src/csi2_payload_crc.sv
src/csi2_rx_ctrl.sv
src/csi2_wb_regs.sv
src/csi2_rx_top.sv
bench/csi2_rx_tb.sv

//--- bench/csi2_rx_tb.sv
`default_nettype none

module csi2_rx_tb
  import csi2_rx_pkg::*;
();

  localparam logic [31:0] SEED_INIT = 32'heb10_1d62;
  // Hamming column of each header bit, bit 5 is P5
  localparam logic [5:0] HDR_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  logic        clk_i;
  logic        srst_i;
  phy_word_t   data_i;
  logic        valid_i;
  logic        error_i;
  logic        phy_rst_o;
  video_beat_t video_o;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  reg_addr_t   wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;

  integer      seed;
  int          err_total;
  int          limit_cycles;
  int          exp_cnt [6];
  logic        phy_rst_q;
  string       cur_case;
  phy_word_t   tx_q [$];
  video_beat_t exp_q [$];
  video_beat_t got_q [$];
  string       names [$];
  string       kinds [$];
  string       faults [$];
  int          dts [$];
  int          wcs [$];
  int          seeds [$];

  csi2_rx_top #(.REG_AW(REG_AW)) dut0
  (
    .clk_i     (clk_i),
    .srst_i    (srst_i),
    .data_i    (data_i),
    .valid_i   (valid_i),
    .error_i   (error_i),
    .phy_rst_o (phy_rst_o),
    .video_o   (video_o),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(negedge clk_i)
    if (video_o.valid)
      got_q.push_back(video_o);

  // PHY re-sync as seen at the end of each word cycle
  always @(posedge clk_i)
    phy_rst_q <= phy_rst_o;

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout after %0d cycles, the run did not complete", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic phy_word_t make_hdr(input data_type_t dt, input logic [15:0] wc);
    logic [23:0] d;
    logic [5:0]  ecc;
    d   = {wc, 2'b00, dt};
    ecc = '0;
    for (int i = 0; i < 24; i++)
      if (d[i])
        ecc = ecc ^ HDR_COL[i];
    return {2'b00, ecc, d};
  endfunction

  task automatic check_phy_rst(input int idx, input int rst_idx);
    logic exp_rst;
    exp_rst = idx == rst_idx;
    if (phy_rst_q !== exp_rst)
    begin
      $display("ERROR %s phy_rst word %0d expected %0b actual %0b", cur_case, idx,
               exp_rst, phy_rst_q);
      err_total++;
    end
  endtask

  // rst_idx is the only word of the packet that resyncs the PHY
  task automatic send_packet(input int rst_idx);
    foreach (tx_q[i])
    begin
      @(negedge clk_i);
      if (i > 0)
        check_phy_rst(i - 1, rst_idx);
      data_i  = tx_q[i];
      valid_i = 1'b1;
    end
    @(negedge clk_i);
    check_phy_rst(tx_q.size() - 1, rst_idx);
    data_i  = '0;
    valid_i = 1'b0;   // Gap between packets
    tx_q    = {};
  endtask

  task automatic send_short(input data_type_t dt);
    tx_q.push_back(make_hdr(dt, 16'h0001));
    send_packet(0);
  endtask

  // Header, payload, CRC low byte first, then the fault
  task automatic build_long(input data_type_t dt, input int wc, input string fault,
                            input bit fwd);
    logic [7:0]  b [$];
    logic [15:0] crc;
    logic        fb;
    logic [3:0]  strb;
    phy_word_t   w;
    int          nw;
    b   = {};
    crc = 16'hFFFF;
    for (int i = 0; i < wc; i++)
      b.push_back(8'($random(seed)));
    foreach (b[i])
      for (int k = 0; k < 8; k++)
      begin
        fb  = crc[0] ^ b[i][k];
        crc = crc >> 1;
        if (fb)
          crc = crc ^ 16'h8408;
      end
    b.push_back(crc[7:0]);
    b.push_back(crc[15:8]);
    w = make_hdr(dt, 16'(wc));
    if (fault == "ecc1")
      w[9] = ~w[9];
    if (fault == "ecc2")
      w = w ^ 32'h0002_0008; // Two data bits, not correctable
    tx_q.push_back(w);
    nw = (b.size() + 3) / 4;
    for (int j = 0; j < nw; j++)
    begin
      w    = '0;
      strb = '0;
      for (int k = 0; k < 4; k++)
        if (4 * j + k < b.size())
        begin
          w[8*k +: 8] = b[4*j + k];
          strb[k]     = 1'b1;
        end
      if (fault == "crc" && j == 0)
        w[0] = ~w[0];
      tx_q.push_back(w);
      if (fwd)
        exp_q.push_back('{valid: 1'b1, data: w, strb: strb, last: j == nw - 1,
                          sof: j == 0, err: fault == "crc" && j == nw - 1});
    end
  endtask

  task automatic wb_access(input logic we, input reg_addr_t adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int t;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    t        = 0;
    do
    begin
      @(negedge clk_i);
      t++;
    end
    while (!wb_ack_o && t < 20);
    if (!wb_ack_o)
    begin
      $display("Wishbone access to register %0d got no ack", adr);
      err_total++;
    end
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
    if (wb_ack_o)
    begin
      $display("Wishbone ack to register %0d stayed high a second cycle", adr);
      err_total++;
    end
  endtask

  task automatic check_counts(input string name);
    logic [31:0] rd;
    for (int i = 0; i < 6; i++)
    begin
      wb_access(1'b0, reg_addr_t'(i + 1), 32'd0, rd);
      if (rd != 32'(exp_cnt[i]))
      begin
        $display("ERROR %s reg %0d expected %0d actual %0d", name, i + 1, exp_cnt[i], rd);
        err_total++;
      end
    end
  endtask

  task automatic run_case(input int n);
    logic [31:0] rd;
    int          start_err;
    int          t;
    string       f;
    start_err = err_total;
    cur_case  = names[n];
    exp_q     = {};
    got_q     = {};
    f         = faults[n];
    seed      = SEED_INIT ^ seeds[n];
    if (kinds[n] == "dis")
      wb_access(1'b1, REG_CTRL, 32'd0, rd);
    if (kinds[n] != "nofrm")
    begin
      send_short(DT_FRAME_START);
      exp_cnt[0]++;
    end
    if (f == "ecc2")
    begin
      build_long(6'(dts[n]), wcs[n], f, 1'b0);
      send_packet(0); // Fatal header resyncs at once
      exp_cnt[3]++;
      f = "none";
    end
    build_long(6'(dts[n]), wcs[n], f, kinds[n] == "frame");
    send_packet(tx_q.size() - 1);
    exp_cnt[1]++;
    if (f == "ecc1")
      exp_cnt[2]++;
    if (f == "crc")
      exp_cnt[4]++;
    if (kinds[n] == "nofrm")
      exp_cnt[5] += 2; // Long packet and frame end while idle
    send_short(DT_FRAME_END);
    t = 0;
    while (got_q.size() < exp_q.size() && t < 200)
    begin
      @(negedge clk_i);
      t++;
    end
    repeat (8) @(negedge clk_i);
    if (got_q.size() != exp_q.size())
    begin
      $display("ERROR %s beats expected %0d actual %0d", names[n], exp_q.size(), got_q.size());
      err_total++;
    end
    else
      foreach (exp_q[j])
        if (got_q[j] != exp_q[j])
        begin
          $display("ERROR %s beat %0d expected %h actual %h", names[n], j, exp_q[j], got_q[j]);
          err_total++;
        end
    if (kinds[n] == "dis")
      wb_access(1'b1, REG_CTRL, 32'd1, rd);
    check_counts(names[n]);
    $display("case %s: %s", names[n], (err_total == start_err) ? "ok" : "failed");
  endtask

  initial
  begin
    integer      fd;
    string       line;
    string       nm;
    string       kd;
    string       ft;
    int          dt;
    int          wc;
    int          sd;
    int          passed;
    int          prev;
    logic [31:0] rd;
    srst_i       = 1'b1;
    data_i       = '0;
    valid_i      = 1'b0;
    error_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    seed         = SEED_INIT;
    err_total    = 0;
    limit_cycles = 0;
    passed       = 0;
    cur_case     = "";
    foreach (exp_cnt[i])
      exp_cnt[i] = 0;
    fd = $fopen("bench/csi2_rx_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the case file bench/csi2_rx_cases.txt");
      $display("=== FAIL ===");
    end
    else
    begin
      while ($fgets(line, fd))
        if (line.len() > 2 && line[0] != "#" &&
            $sscanf(line, "%s %s %h %d %h %s", nm, kd, dt, wc, sd, ft) == 6)
        begin
          names.push_back(nm);
          kinds.push_back(kd);
          dts.push_back(dt);
          wcs.push_back(wc);
          seeds.push_back(sd);
          faults.push_back(ft);
        end
      $fclose(fd);
      limit_cycles = 400;  // Reset and final clear
      foreach (wcs[i])
        limit_cycles += wcs[i] * 4 + 200;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      srst_i = 1'b0;
      foreach (names[i])
      begin
        prev = err_total;
        run_case(i);
        if (err_total == prev)
          passed++;
      end
      wb_access(1'b1, REG_CTRL, 32'd3, rd); // Keep enable, clear counters
      foreach (exp_cnt[i])
        exp_cnt[i] = 0;
      check_counts("clear");
      $display("%0d cases run, %0d passed, %0d failed, %0d errors", names.size(), passed,
               names.size() - passed, err_total);
      if (err_total == 0 && names.size() > 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/csi2_rx_top.sv
`default_nettype none

module csi2_rx_top
  import csi2_rx_pkg::*;
#(
  parameter int REG_AW = csi2_rx_pkg::REG_AW
)
(
  input  logic              clk_i,
  input  logic              srst_i,
  input  phy_word_t         data_i,
  input  logic              valid_i,
  input  logic              error_i,
  output logic              phy_rst_o,
  output video_beat_t       video_o,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [REG_AW-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o
);

  pkt_beat_t   beat;
  hdr_status_t hdr_status;
  logic        crc_done;
  logic        crc_ok;
  logic        enable;
  logic        in_frame;
  rx_event_t   events;

  csi2_pkt_framer framer0
  (
    .clk_i        (clk_i),
    .srst_i       (srst_i),
    .data_i       (data_i),
    .valid_i      (valid_i),
    .error_i      (error_i),
    .phy_rst_o    (phy_rst_o),
    .beat_o       (beat),
    .hdr_status_o (hdr_status)
  );

  csi2_payload_crc crc0
  (
    .clk_i      (clk_i),
    .srst_i     (srst_i),
    .beat_i     (beat),
    .crc_done_o (crc_done),
    .crc_ok_o   (crc_ok)
  );

  csi2_rx_ctrl ctrl0
  (
    .clk_i        (clk_i),
    .srst_i       (srst_i),
    .beat_i       (beat),
    .hdr_status_i (hdr_status),
    .crc_done_i   (crc_done),
    .crc_ok_i     (crc_ok),
    .enable_i     (enable),
    .in_frame_o   (in_frame),
    .video_o      (video_o),
    .events_o     (events)
  );

  csi2_wb_regs #(
    .REG_AW (REG_AW)
  ) regs0
  (
    .clk_i      (clk_i),
    .srst_i     (srst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .events_i   (events),
    .in_frame_i (in_frame),
    .enable_o   (enable)
  );

endmodule

`default_nettype wire

//--- src/csi2_wb_regs.sv
`default_nettype none

module csi2_wb_regs
  import csi2_rx_pkg::*;
#(
  parameter int REG_AW = csi2_rx_pkg::REG_AW
)
(
  input  logic              clk_i,
  input  logic              srst_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [REG_AW-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o,
  input  rx_event_t         events_i,
  input  logic              in_frame_i,
  output logic              enable_o
);

  logic        wb_req;
  logic        clr;
  logic [5:0]  ev;
  logic [15:0] cnt [6];
  logic [31:0] rd_data;

  assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign clr    = wb_req && wb_we_i && wb_adr_i == REG_AW'(REG_CTRL) && wb_dat_i[1];
  assign ev     = {events_i.sync_error, events_i.crc_error, events_i.ecc_fatal,
                   events_i.ecc_corrected, events_i.long_pkt, events_i.frame_start};

  always_comb
    case (wb_adr_i)
      REG_AW'(REG_CTRL):      rd_data = {31'd0, enable_o};
      REG_AW'(REG_FRAMES):    rd_data = {16'd0, cnt[0]};
      REG_AW'(REG_LONG_PKTS): rd_data = {16'd0, cnt[1]};
      REG_AW'(REG_ECC_CORR):  rd_data = {16'd0, cnt[2]};
      REG_AW'(REG_ECC_FATAL): rd_data = {16'd0, cnt[3]};
      REG_AW'(REG_CRC_ERR):   rd_data = {16'd0, cnt[4]};
      REG_AW'(REG_SYNC_ERR):  rd_data = {16'd0, cnt[5]};
      REG_AW'(REG_STATUS):    rd_data = {31'd0, in_frame_i};
      default:                rd_data = '0;
    endcase

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      enable_o <= 1'b1;
    end
    else
    begin
      wb_ack_o <= wb_req;
      if (wb_req)
        wb_dat_o <= rd_data;
      if (wb_req && wb_we_i && wb_adr_i == REG_AW'(REG_CTRL))
        enable_o <= wb_dat_i[0];
    end

  // Saturating event counters
  always_ff @(posedge clk_i)
    for (int i = 0; i < 6; i++)
      if (srst_i || clr)
        cnt[i] <= '0;
      else if (ev[i] && cnt[i] != 16'hFFFF)
        cnt[i] <= cnt[i] + 16'd1;

  // Master drops stb once its access is acked
  a_stb_drop: assert property (@(posedge clk_i) disable iff (srst_i)
    wb_ack_o |=> !wb_stb_i);

endmodule

`default_nettype wire

//--- src/csi2_rx_ctrl.sv
`default_nettype none

module csi2_rx_ctrl
  import csi2_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        srst_i,
  input  pkt_beat_t   beat_i,
  input  hdr_status_t hdr_status_i,
  input  logic        crc_done_i,
  input  logic        crc_ok_i,
  input  logic        enable_i,
  output logic        in_frame_o,
  output video_beat_t video_o,
  output rx_event_t   events_o
);

  rx_state_t   state;
  data_type_t  dt;
  logic        hdr_beat;
  logic        pay_beat;
  logic        fwd;       // Current long packet goes to the output
  logic        sof_pend;
  logic        held;
  video_beat_t hold_q;

  assign dt         = data_type_t'(beat_i.data[5:0]);
  assign hdr_beat   = beat_i.valid && beat_i.hdr;
  assign pay_beat   = beat_i.valid && !beat_i.hdr;
  assign in_frame_o = state != ST_IDLE;

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      state    <= ST_IDLE;
      fwd      <= 1'b0;
      sof_pend <= 1'b0;
      events_o <= '0;
    end
    else
    begin
      events_o               <= '0;
      events_o.ecc_corrected <= hdr_status_i == HDR_CORRECTED;
      events_o.ecc_fatal     <= hdr_status_i == HDR_FATAL;
      events_o.crc_error     <= crc_done_i && !crc_ok_i;
      if (hdr_beat && dt < LONG_PKT_MIN)
        case (dt)
          DT_FRAME_START:
          begin
            events_o.frame_start <= 1'b1;
            events_o.sync_error  <= state != ST_IDLE;
            state                <= ST_IN_FRAME;
            sof_pend             <= 1'b1;
          end
          DT_FRAME_END:
          begin
            events_o.frame_end  <= state != ST_IDLE;
            events_o.sync_error <= state == ST_IDLE;
            state               <= ST_IDLE;
          end
          DT_LINE_START, DT_LINE_END:
            if (state == ST_IN_PAYLOAD)
              state <= ST_IN_FRAME; // Previous payload was cut short
          default: ;
        endcase
      else if (hdr_beat)
      begin
        events_o.long_pkt   <= 1'b1;
        events_o.sync_error <= state == ST_IDLE;
        fwd                 <= enable_i && state != ST_IDLE;
        if (state != ST_IDLE)
          state <= ST_IN_PAYLOAD;
      end
      else if (pay_beat)
      begin
        if (fwd)
          sof_pend <= 1'b0;
        if (beat_i.last && state == ST_IN_PAYLOAD)
          state <= ST_IN_FRAME;
      end
    end

  // Final beat waits here for the CRC result
  always_ff @(posedge clk_i)
    if (pay_beat && beat_i.last)
      hold_q <= '{valid: fwd, data: beat_i.data, strb: beat_i.strb, last: 1'b1,
                  sof: sof_pend && fwd, err: 1'b0};

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      video_o <= '0;
      held    <= 1'b0;
    end
    else
    begin
      video_o.valid <= 1'b0;
      if (crc_done_i && held)
      begin
        video_o     <= hold_q;
        video_o.err <= !crc_ok_i;
        held        <= 1'b0;
      end
      else if (pay_beat && beat_i.last)
        held <= 1'b1;
      else if (pay_beat)
        video_o <= '{valid: fwd, data: beat_i.data, strb: beat_i.strb, last: 1'b0,
                     sof: sof_pend && fwd, err: 1'b0};
    end

  a_crc_held: assert property (@(posedge clk_i) disable iff (srst_i)
    crc_done_i |-> held);

endmodule

`default_nettype wire

//--- src/csi2_payload_crc.sv
`default_nettype none

module csi2_payload_crc
  import csi2_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      srst_i,
  input  pkt_beat_t beat_i,
  output logic      crc_done_o,
  output logic      crc_ok_o
);

  // CRC-16 x16+x12+x5+1, LSB first
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc ^ {8'h00, b};
    for (int k = 0; k < 8; k++)
      c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
    return c;
  endfunction

  logic            long_act;
  logic            pay_beat;
  logic [15:0]     crc_q;
  logic [15:0]     crc_nxt;
  logic [1:0][7:0] dly_q;   // Index 0 holds the older byte
  logic [1:0][7:0] dly_nxt;
  logic [1:0]      fill_q;
  logic [1:0]      fill_nxt;

  assign pay_beat = beat_i.valid && !beat_i.hdr && long_act;

  always_comb
  begin
    crc_nxt  = crc_q;
    dly_nxt  = dly_q;
    fill_nxt = fill_q;
    for (int i = 0; i < 4; i++)
      if (beat_i.strb[i])
      begin
        if (fill_nxt == 2'd2)
        begin
          crc_nxt    = crc16_byte(crc_nxt, dly_nxt[0]);
          dly_nxt[0] = dly_nxt[1];
          dly_nxt[1] = beat_i.data[8*i +: 8];
        end
        else if (fill_nxt == 2'd1)
        begin
          dly_nxt[1] = beat_i.data[8*i +: 8];
          fill_nxt   = 2'd2;
        end
        else
        begin
          dly_nxt[0] = beat_i.data[8*i +: 8];
          fill_nxt   = 2'd1;
        end
      end
  end

  always_ff @(posedge clk_i)
    if (beat_i.valid && beat_i.hdr)
      crc_q <= 16'hFFFF;
    else if (pay_beat)
    begin
      crc_q <= crc_nxt;
      dly_q <= dly_nxt;
    end

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      long_act   <= 1'b0;
      fill_q     <= '0;
      crc_done_o <= 1'b0;
      crc_ok_o   <= 1'b0;
    end
    else
    begin
      crc_done_o <= 1'b0;
      crc_ok_o   <= 1'b0;
      if (beat_i.valid && beat_i.hdr)
      begin
        long_act <= data_type_t'(beat_i.data[5:0]) >= LONG_PKT_MIN;
        fill_q   <= '0;
      end
      else if (pay_beat)
      begin
        fill_q <= fill_nxt;
        if (beat_i.last)
        begin
          long_act   <= 1'b0;
          crc_done_o <= 1'b1;
          crc_ok_o   <= crc_nxt == 16'(dly_nxt); // Received CRC, low byte first
        end
      end
    end

endmodule

`default_nettype wire

//--- src/csi2_pkt_framer.sv
`default_nettype none

module csi2_pkt_framer
  import csi2_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        srst_i,
  input  phy_word_t   data_i,
  input  logic        valid_i,
  input  logic        error_i,
  output logic        phy_rst_o,
  output pkt_beat_t   beat_o,
  output hdr_status_t hdr_status_o
);

  phy_word_t   hdr_fix;
  hdr_status_t hdr_status;
  logic        valid_d1;
  logic        pkt_running;
  logic        header_valid;
  logic        fatal_hdr;
  logic        good_hdr;
  logic        short_pkt;
  logic        long_pkt;
  logic        run_word;
  logic        last_word;
  logic [3:0]  last_strb;
  byte_cnt_t   byte_cnt;
  byte_cnt_t   byte_cnt_nxt;

  csi2_hdr_ecc hdr_ecc0
  (
    .hdr_i    (data_i),
    .hdr_o    (hdr_fix),
    .status_o (hdr_status)
  );

  assign header_valid = valid_i && !valid_d1 && !error_i && !pkt_running;
  assign fatal_hdr    = header_valid && hdr_status == HDR_FATAL;
  assign good_hdr     = header_valid && !fatal_hdr;
  assign long_pkt     = good_hdr && data_type_t'(hdr_fix[5:0]) >= LONG_PKT_MIN;
  assign short_pkt    = good_hdr && data_type_t'(hdr_fix[5:0]) < LONG_PKT_MIN;
  assign run_word     = pkt_running && valid_i;
  assign last_word    = run_word && byte_cnt <= 16'd4;
  assign phy_rst_o    = short_pkt || last_word || error_i || fatal_hdr;

  always_comb
  begin
    byte_cnt_nxt = byte_cnt;
    if (long_pkt)
      byte_cnt_nxt = byte_cnt_t'(hdr_fix[23:8]) + 16'd2; // Payload plus CRC bytes
    else if (run_word)
      byte_cnt_nxt = (byte_cnt < 16'd4) ? 16'd0 : byte_cnt - 16'd4;
  end

  always_comb
    for (int i = 0; i < 4; i++)
      last_strb[i] = byte_cnt > 16'(i);

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      valid_d1    <= 1'b0;
      pkt_running <= 1'b0;
      byte_cnt    <= '0;
    end
    else
    begin
      valid_d1 <= valid_i;
      byte_cnt <= byte_cnt_nxt;
      if (long_pkt)
        pkt_running <= 1'b1;
      else if (phy_rst_o)
        pkt_running <= 1'b0;
    end

  always_ff @(posedge clk_i)
    if (srst_i)
    begin
      beat_o       <= '0;
      hdr_status_o <= HDR_OK;
    end
    else
    begin
      beat_o.valid <= good_hdr || run_word;
      beat_o.data  <= good_hdr ? hdr_fix : data_i;
      beat_o.strb  <= last_word ? last_strb : 4'hF;
      beat_o.last  <= short_pkt || last_word;
      beat_o.hdr   <= good_hdr;
      hdr_status_o <= header_valid ? hdr_status : HDR_OK; // Fatal shows without a beat
    end

  // Long packet words arrive without gaps unless the PHY flags an error
  a_pkt_contiguous: assert property (@(posedge clk_i) disable iff (srst_i)
    pkt_running && !error_i |-> valid_i);

endmodule

`default_nettype wire

//--- src/csi2_hdr_ecc.sv
`default_nettype none

module csi2_hdr_ecc
  import csi2_rx_pkg::*;
(
  input  phy_word_t   hdr_i,
  output phy_word_t   hdr_o,
  output hdr_status_t status_o
);

  // Syndrome column of each header data bit, bit 5 is P5
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  logic [5:0] calc_ecc;
  logic [5:0] syndrome;
  logic       hit;

  always_comb
  begin
    calc_ecc = '0;
    for (int i = 0; i < 24; i++)
      if (hdr_i[i])
        calc_ecc = calc_ecc ^ ECC_COL[i];
  end

  assign syndrome = calc_ecc ^ hdr_i[29:24];

  always_comb
  begin
    hdr_o    = hdr_i;
    status_o = HDR_OK;
    hit      = 1'b0;
    if (syndrome != 6'd0)
    begin
      // Error in a data bit
      for (int i = 0; i < 24; i++)
        if (syndrome == ECC_COL[i])
        begin
          hdr_o[i] = ~hdr_i[i];
          hit      = 1'b1;
        end
      // Error in the ECC field itself
      for (int j = 0; j < 6; j++)
        if (syndrome == 6'(1 << j))
        begin
          hdr_o[24 + j] = ~hdr_i[24 + j];
          hit           = 1'b1;
        end
      status_o = hit ? HDR_CORRECTED : HDR_FATAL;
    end
  end

endmodule

`default_nettype wire

//--- src/csi2_rx_pkg.sv
`default_nettype none

package csi2_rx_pkg;

  typedef logic [31:0] phy_word_t;
  typedef logic [15:0] byte_cnt_t;
  typedef logic [5:0]  data_type_t;

  // Short packet codes
  localparam data_type_t DT_FRAME_START = 6'h00;
  localparam data_type_t DT_FRAME_END   = 6'h01;
  localparam data_type_t DT_LINE_START  = 6'h02;
  localparam data_type_t DT_LINE_END    = 6'h03;
  localparam data_type_t LONG_PKT_MIN   = 6'h10; // At or above means long packet

  typedef struct packed {
    logic        valid;
    phy_word_t   data;
    logic [3:0]  strb;
    logic        last;
    logic        hdr;   // Header beat
  } pkt_beat_t;

  typedef enum logic [1:0] {HDR_OK, HDR_CORRECTED, HDR_FATAL} hdr_status_t;

  // One-cycle event pulses
  typedef struct packed {
    logic frame_start;
    logic frame_end;
    logic long_pkt;
    logic ecc_corrected;
    logic ecc_fatal;
    logic crc_error;
    logic sync_error;
  } rx_event_t;

  typedef struct packed {
    logic        valid;
    phy_word_t   data;
    logic [3:0]  strb;
    logic        last;
    logic        sof;   // First payload beat of a frame
    logic        err;   // CRC failure, last beat only
  } video_beat_t;

  typedef enum logic [1:0] {ST_IDLE, ST_IN_FRAME, ST_IN_PAYLOAD} rx_state_t;

  localparam int REG_AW = 3;
  typedef logic [REG_AW-1:0] reg_addr_t;

  localparam reg_addr_t REG_CTRL      = 3'd0;
  localparam reg_addr_t REG_FRAMES    = 3'd1;
  localparam reg_addr_t REG_LONG_PKTS = 3'd2;
  localparam reg_addr_t REG_ECC_CORR  = 3'd3;
  localparam reg_addr_t REG_ECC_FATAL = 3'd4;
  localparam reg_addr_t REG_CRC_ERR   = 3'd5;
  localparam reg_addr_t REG_SYNC_ERR  = 3'd6;
  localparam reg_addr_t REG_STATUS    = 3'd7;

endpackage

`default_nettype wire
